/* verilog/alu_pkg.sv */
/*
 * widths, operator codes and class helpers for the RV32 ALU
 * operator codes are local to this design, not RISC-V funct fields
 */
`default_nettype none

package alu_pkg;

  //////////////////////
  // widths
  //////////////////////
  localparam int unsigned XLEN    = 32;
  // shift amount comes from the low bits of operand b
  localparam int unsigned SHAMT_W = 5;
  // a bit count can reach XLEN, so one extra bit
  localparam int unsigned CNT_W   = 6;

  typedef logic [XLEN-1:0] alu_word_t;

  //////////////////////
  // operators
  //////////////////////
  typedef enum logic [4:0] {
    // adder
    ALU_ADD, ALU_SUB,
    // bitwise, with negated-b forms
    ALU_XOR, ALU_OR, ALU_AND, ALU_XNOR, ALU_ORN, ALU_ANDN,
    // shifts
    ALU_SRA, ALU_SRL, ALU_SLL,
    // compares
    ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_EQ, ALU_NE, ALU_SLT, ALU_SLTU,
    // min / max
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    // bit counting
    ALU_CLZ, ALU_CTZ, ALU_PCNT
  } alu_op_e;

  // compares plus min/max, all of them run a - b through the adder
  function automatic logic is_cmp_op(alu_op_e op);
    logic res;
    case (op)
      ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
      ALU_SLT, ALU_SLTU, ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU: res = 1'b1;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  // operators that treat the operands as two's complement
  function automatic logic is_signed_cmp(alu_op_e op);
    logic res;
    case (op)
      ALU_LT, ALU_GE, ALU_SLT, ALU_MIN, ALU_MAX: res = 1'b1;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

/* verilog/alu_dp_if.sv */
/*
 * request and adder sum bundle inside the ALU core
 * purely combinational, valid for the request held by the top
 */
`timescale 1ns/1ps
`default_nettype none

interface alu_dp_if
  import alu_pkg::*;
();

  // request as seen by the core
  alu_op_e   op;
  alu_word_t operand_a;
  alu_word_t operand_b;
  // upper XLEN bits of the 33-bit adder
  alu_word_t adder_sum;

  modport core_mp (
    output op,
    output operand_a,
    output operand_b,
    input  adder_sum
  );

  modport adder_mp (
    input  op,
    input  operand_a,
    input  operand_b,
    output adder_sum
  );

  modport compare_mp (
    input  op,
    input  operand_a,
    input  operand_b,
    input  adder_sum
  );

endinterface

`default_nettype wire

/* verilog/alu_adder.sv */
/*
 * shared adder for add, sub and every compare
 * subtraction uses a 33-bit add with the carry-in folded into bit 0
 */
`timescale 1ns/1ps
`default_nettype none

module alu_adder
  import alu_pkg::*;
(
  alu_dp_if.adder_mp dp
);

  logic          negate_b;
  logic [XLEN:0] adder_in_a;
  logic [XLEN:0] adder_in_b;
  logic [XLEN:0] adder_out;

  // sub and all compare / min / max forms compute a - b
  assign negate_b = (dp.op == ALU_SUB) || is_cmp_op(dp.op);

  // operand a gets a constant 1 below its lsb
  assign adder_in_a = {dp.operand_a, 1'b1};

  // operand b sits one bit up
  // inverting the whole 33 bits turns the low 0 into 1,
  // so 1 + 1 in the low column carries the +1 of two's complement
  always_comb begin
    if (negate_b) begin
      adder_in_b = ~{dp.operand_b, 1'b0};
    end else begin
      adder_in_b = {dp.operand_b, 1'b0};
    end
  end

  // bit 0 of the sum is only the carry helper
  assign adder_out = adder_in_a + adder_in_b;

  // drop the helper column, wraps modulo 2^XLEN
  assign dp.adder_sum = adder_out[XLEN:1];

endmodule

`default_nettype wire

/* verilog/alu_shifter.sv */
/*
 * sll, srl and sra on one 33-bit arithmetic right shifter
 * only the low SHAMT_W bits of operand b are used as the amount
 * left shifts reverse the operand before and after the shift
 */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter
  import alu_pkg::*;
(
  input  alu_op_e   op_i,
  input  alu_word_t operand_a_i,
  input  alu_word_t operand_b_i,
  output alu_word_t shift_result_o
);

  logic               shift_left;
  logic               shift_arith;
  logic [SHAMT_W-1:0] shift_amt;
  alu_word_t          operand_a_rev;
  alu_word_t          shift_in;
  logic [XLEN:0]      shift_ext;
  alu_word_t          shift_raw;
  alu_word_t          shift_raw_rev;

  assign shift_left  = (op_i == ALU_SLL);
  assign shift_arith = (op_i == ALU_SRA);

  // amount above 31 wraps, e.g. 33 shifts by 1
  assign shift_amt = operand_b_i[SHAMT_W-1:0];

  // bit reversal of operand a, msb lands at bit 0
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev_in
    assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
  end

  // left shift is done as a right shift of the reversed word
  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // extension bit is the sign only for sra, zero otherwise
  // sll reaches here reversed, so zeros enter from the right after undoing it
  assign shift_ext = $signed({shift_arith & shift_in[XLEN-1], shift_in}) >>> shift_amt;

  assign shift_raw = shift_ext[XLEN-1:0];

  // undo the reversal for sll
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev_out
    assign shift_raw_rev[k] = shift_raw[XLEN-1-k];
  end

  always_comb begin
    if (shift_left) begin
      shift_result_o = shift_raw_rev;
    end else begin
      shift_result_o = shift_raw;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_compare.sv */
/*
 * compare and min/max, derived from the a - b sum of the adder
 * cmp_result_o is meaningful only for compare and min/max operators
 */
`timescale 1ns/1ps
`default_nettype none

module alu_compare
  import alu_pkg::*;
(
  alu_dp_if.compare_mp dp,
  output logic         cmp_result_o,
  output alu_word_t    minmax_result_o
);

  logic is_equal;
  logic is_greater_equal;
  logic cmp_signed;
  logic sign_a;
  logic sign_b;

  assign cmp_signed = is_signed_cmp(dp.op);
  assign sign_a     = dp.operand_a[XLEN-1];
  assign sign_b     = dp.operand_b[XLEN-1];

  // a - b is zero only when a equals b
  assign is_equal = (dp.adder_sum == '0);

  // equal msbs, the difference cannot overflow so its sign decides
  // differing msbs, a wins unsigned when its msb is set
  // and loses signed, hence the xor with the signed flag
  always_comb begin
    if (sign_a == sign_b) begin
      is_greater_equal = ~dp.adder_sum[XLEN-1];
    end else begin
      is_greater_equal = sign_a ^ cmp_signed;
    end
  end

  // per-operator view of the comparison
  always_comb begin
    case (dp.op)
      ALU_EQ:   cmp_result_o = is_equal;
      ALU_NE:   cmp_result_o = ~is_equal;
      ALU_GE, ALU_GEU,
      ALU_MAX, ALU_MAXU: cmp_result_o = is_greater_equal;
      ALU_LT, ALU_LTU,
      ALU_SLT, ALU_SLTU,
      ALU_MIN, ALU_MINU: cmp_result_o = ~is_greater_equal;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  // min picks a when a < b, max picks a when a >= b
  always_comb begin
    if (cmp_result_o) begin
      minmax_result_o = dp.operand_a;
    end else begin
      minmax_result_o = dp.operand_b;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_bitcount.sv */
/*
 * clz, ctz and pcnt over operand a
 * zero input gives XLEN for clz and ctz
 */
`timescale 1ns/1ps
`default_nettype none

module alu_bitcount
  import alu_pkg::*;
(
  input  alu_op_e          op_i,
  input  alu_word_t        operand_a_i,
  output logic [CNT_W-1:0] count_o
);

  logic      bitcnt_ctz;
  logic      bitcnt_pcnt;
  alu_word_t operand_a_rev;
  alu_word_t bitcnt_bits;

  assign bitcnt_ctz  = (op_i == ALU_CTZ);
  assign bitcnt_pcnt = (op_i == ALU_PCNT);

  // clz scans from the msb, so count trailing ones of the reversed word
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev
    assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
  end

  // zeros of interest become ones, pcnt counts the raw ones
  always_comb begin
    if (bitcnt_pcnt) begin
      bitcnt_bits = operand_a_i;
    end else if (bitcnt_ctz) begin
      bitcnt_bits = ~operand_a_i;
    end else begin
      bitcnt_bits = ~operand_a_rev;
    end
  end

  // ripple count from bit 0
  // the enable drops at the first zero, pcnt keeps it on throughout
  always_comb begin
    logic enable;
    enable  = 1'b1;
    count_o = '0;
    for (int unsigned i = 0; i < XLEN; i++) begin
      if (enable) begin
        count_o = count_o + CNT_W'(bitcnt_bits[i]);
      end
      enable = bitcnt_pcnt || (enable && bitcnt_bits[i]);
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_core.sv */
/*
 * combinational ALU datapath, zero-cycle latency
 * operands must be stable for the whole evaluation, the top holds them
 */
`timescale 1ns/1ps
`default_nettype none

module alu_core
  import alu_pkg::*;
(
  input  alu_op_e   op_i,
  input  alu_word_t operand_a_i,
  input  alu_word_t operand_b_i,
  output alu_word_t result_o,
  output logic      cmp_result_o
);

  alu_word_t        shift_result;
  alu_word_t        minmax_result;
  logic [CNT_W-1:0] bitcnt_result;
  logic             bwlogic_negate;
  alu_word_t        bwlogic_operand_b;
  alu_word_t        bwlogic_result;

  alu_dp_if dp ();

  // request into the shared bundle
  assign dp.op        = op_i;
  assign dp.operand_a = operand_a_i;
  assign dp.operand_b = operand_b_i;

  //////////////////////
  // units
  //////////////////////
  alu_adder u_adder (
    .dp (dp.adder_mp)
  );

  alu_shifter u_shifter (
    .op_i           (op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .shift_result_o (shift_result)
  );

  alu_compare u_compare (
    .dp              (dp.compare_mp),
    .cmp_result_o    (cmp_result_o),
    .minmax_result_o (minmax_result)
  );

  alu_bitcount u_bitcount (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .count_o     (bitcnt_result)
  );

  //////////////////////
  // bitwise logic
  //////////////////////
  // xnor, orn and andn are the plain ops with b inverted
  assign bwlogic_negate    = (op_i == ALU_XNOR) || (op_i == ALU_ORN) || (op_i == ALU_ANDN);
  assign bwlogic_operand_b = bwlogic_negate ? ~operand_b_i : operand_b_i;

  always_comb begin
    case (op_i)
      ALU_OR, ALU_ORN:   bwlogic_result = operand_a_i | bwlogic_operand_b;
      ALU_AND, ALU_ANDN: bwlogic_result = operand_a_i & bwlogic_operand_b;
      default:           bwlogic_result = operand_a_i ^ bwlogic_operand_b;
    endcase
  end

  //////////////////////
  // result mux
  //////////////////////
  always_comb begin
    case (op_i)
      ALU_XOR, ALU_OR, ALU_AND,
      ALU_XNOR, ALU_ORN, ALU_ANDN: result_o = bwlogic_result;
      ALU_ADD, ALU_SUB:            result_o = dp.adder_sum;
      ALU_SLL, ALU_SRL, ALU_SRA:   result_o = shift_result;
      // compare bit goes out as 0 or 1
      ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU,
      ALU_SLT, ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
      ALU_MIN, ALU_MINU,
      ALU_MAX, ALU_MAXU:           result_o = minmax_result;
      ALU_CLZ, ALU_CTZ, ALU_PCNT:  result_o = {{(XLEN-CNT_W){1'b0}}, bitcnt_result};
      default:                     result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
/*
 * registered ALU behind a four-phase req/ack handshake, one request in flight
 * op and operands are sampled once, on the capture edge
 * ack rises two edges after req is sampled and falls once req is seen low
 */
`timescale 1ns/1ps
`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  alu_op_e   op_i,
  input  alu_word_t operand_a_i,
  input  alu_word_t operand_b_i,
  output logic      ack_o,
  output alu_word_t result_o,
  output logic      cmp_result_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COMPUTE,
    ST_ACK
  } hs_state_e;

  hs_state_e state_q;
  logic      ack_q;
  logic      capture;
  alu_op_e   op_q;
  alu_word_t operand_a_q;
  alu_word_t operand_b_q;
  alu_word_t result_q;
  logic      cmp_result_q;
  alu_word_t core_result;
  logic      core_cmp_result;

  // new request only while idle with ack already low
  assign capture = req_i && !ack_q && (state_q == ST_IDLE);

  //////////////////////
  // handshake FSM
  //////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      ack_q        <= 1'b0;
      result_q     <= '0;
      cmp_result_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (capture) begin
            state_q <= ST_COMPUTE;
          end
        end
        ST_COMPUTE: begin
          // core output settled from the captured request
          state_q      <= ST_ACK;
          ack_q        <= 1'b1;
          result_q     <= core_result;
          cmp_result_q <= is_cmp_op(op_q) & core_cmp_result;
        end
        ST_ACK: begin
          // results stay held while the requester keeps req high
          if (!req_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request registers
  always_ff @(posedge clk_i) begin
    if (capture) begin
      op_q        <= op_i;
      operand_a_q <= operand_a_i;
      operand_b_q <= operand_b_i;
    end
  end

  alu_core u_core (
    .op_i         (op_q),
    .operand_a_i  (operand_a_q),
    .operand_b_i  (operand_b_q),
    .result_o     (core_result),
    .cmp_result_o (core_cmp_result)
  );

  assign ack_o        = ack_q;
  assign result_o     = result_q;
  assign cmp_result_o = cmp_result_q;

endmodule

`default_nettype wire

/* tb/alu_tb_vectors.svh */
/*
 * stimulus and expected results, included inside the testbench module
 * columns: operator, operand a, operand b, expected result, expected compare bit
 */
`ifndef ALU_TB_VECTORS_SVH
`define ALU_TB_VECTORS_SVH

// one call per table entry, applied in this order
task automatic load_vectors();
  // adder wraps modulo 2^32
  add_vector(ALU_ADD,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
  add_vector(ALU_SUB,  32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0);
  add_vector(ALU_ADD,  32'h1234_5678, 32'h1111_1111, 32'h2345_6789, 1'b0);
  add_vector(ALU_SUB,  32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b0);
  // bitwise, negated forms use ~b = f00f_00ff
  add_vector(ALU_XOR,  32'hf0f0_1234, 32'h0ff0_ff00, 32'hff00_ed34, 1'b0);
  add_vector(ALU_OR,   32'hf0f0_1234, 32'h0ff0_ff00, 32'hfff0_ff34, 1'b0);
  add_vector(ALU_AND,  32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200, 1'b0);
  add_vector(ALU_XNOR, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00ff_12cb, 1'b0);
  add_vector(ALU_ORN,  32'hf0f0_1234, 32'h0ff0_ff00, 32'hf0ff_12ff, 1'b0);
  add_vector(ALU_ANDN, 32'hf0f0_1234, 32'h0ff0_ff00, 32'hf000_0034, 1'b0);
  // shifts, amount 33 acts as 1 and ffff_ffe0 as 0
  add_vector(ALU_SRA,  32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 1'b0);
  add_vector(ALU_SRL,  32'h8000_0000, 32'h0000_0004, 32'h0800_0000, 1'b0);
  add_vector(ALU_SRA,  32'hffff_0000, 32'h0000_0008, 32'hffff_ff00, 1'b0);
  add_vector(ALU_SLL,  32'h0000_0001, 32'h0000_0021, 32'h0000_0002, 1'b0);
  add_vector(ALU_SRL,  32'h8000_0000, 32'h0000_0021, 32'h4000_0000, 1'b0);
  add_vector(ALU_SLL,  32'hf000_000f, 32'h0000_0004, 32'h0000_00f0, 1'b0);
  add_vector(ALU_SLL,  32'h1234_5678, 32'hffff_ffe0, 32'h1234_5678, 1'b0);
  // mixed sign, signed and unsigned disagree
  add_vector(ALU_LT,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b1);
  add_vector(ALU_LTU,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
  add_vector(ALU_GE,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
  add_vector(ALU_GEU,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b1);
  add_vector(ALU_SLT,  32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
  add_vector(ALU_SLTU, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0000, 1'b0);
  // same sign, the difference decides
  add_vector(ALU_LT,   32'h0000_0003, 32'h0000_0007, 32'h0000_0001, 1'b1);
  add_vector(ALU_GEU,  32'h0000_0007, 32'h0000_0007, 32'h0000_0001, 1'b1);
  add_vector(ALU_EQ,   32'h0000_0005, 32'h0000_0005, 32'h0000_0001, 1'b1);
  add_vector(ALU_NE,   32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 1'b0);
  add_vector(ALU_EQ,   32'h0000_0005, 32'h0000_0006, 32'h0000_0000, 1'b0);
  add_vector(ALU_NE,   32'h0000_0005, 32'h0000_0006, 32'h0000_0001, 1'b1);
  // min/max of -16 and 10, compare bit is lt for min and ge for max
  add_vector(ALU_MIN,  32'hffff_fff0, 32'h0000_000a, 32'hffff_fff0, 1'b1);
  add_vector(ALU_MINU, 32'hffff_fff0, 32'h0000_000a, 32'h0000_000a, 1'b0);
  add_vector(ALU_MAX,  32'hffff_fff0, 32'h0000_000a, 32'h0000_000a, 1'b0);
  add_vector(ALU_MAXU, 32'hffff_fff0, 32'h0000_000a, 32'hffff_fff0, 1'b1);
  add_vector(ALU_MIN,  32'h0000_0005, 32'h0000_0005, 32'h0000_0005, 1'b0);
  // bit counting, operand b is ignored
  add_vector(ALU_CLZ,  32'h0000_0000, 32'hdead_beef, 32'h0000_0020, 1'b0);
  add_vector(ALU_CTZ,  32'h0000_0000, 32'hdead_beef, 32'h0000_0020, 1'b0);
  add_vector(ALU_PCNT, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0020, 1'b0);
  add_vector(ALU_CLZ,  32'h0000_0001, 32'h0000_0000, 32'h0000_001f, 1'b0);
  add_vector(ALU_CTZ,  32'h8000_0000, 32'h0000_0000, 32'h0000_001f, 1'b0);
  add_vector(ALU_PCNT, 32'hf0f0_1234, 32'h0000_0000, 32'h0000_000d, 1'b0);
  add_vector(ALU_CLZ,  32'h0001_0000, 32'h0000_0000, 32'h0000_000f, 1'b0);
  add_vector(ALU_CTZ,  32'h0000_0100, 32'h0000_0000, 32'h0000_0008, 1'b0);
  add_vector(ALU_CLZ,  32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 1'b0);
endtask

`endif

/* tb/alu_tb.sv */
/*
 * testbench for alu_top, vectors from alu_tb_vectors.svh
 * inputs change and outputs are sampled 1 ns after the rising edge
 */
`timescale 1ns/1ps
`default_nettype none

module alu_tb
  import alu_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned RESET_CYCLES = 4;
  localparam int unsigned DRIVE_DELAY  = 1;
  // edges from driving req until ack is seen high
  localparam int unsigned ACK_LATENCY  = 2;

  typedef struct packed {
    alu_op_e   op;
    alu_word_t operand_a;
    alu_word_t operand_b;
    alu_word_t result;
    logic      cmp_result;
  } vector_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  alu_op_e     op;
  alu_word_t   operand_a;
  alu_word_t   operand_b;
  logic        ack;
  alu_word_t   result;
  logic        cmp_result;
  vector_t     vectors[$];
  int unsigned cycle_cnt;

  alu_top DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .op_i         (op),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .ack_o        (ack),
    .result_o     (result),
    .cmp_result_o (cmp_result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////
  // helpers
  //////////////////////
  task automatic fail_run(input string reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic report_mismatch(input string what, input alu_word_t got, input alu_word_t exp);
    $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    fail_run("the DUT returned a wrong value");
  endtask

  task automatic add_vector(input alu_op_e op_v, input alu_word_t a, input alu_word_t b,
                            input alu_word_t res, input logic cmp);
    vector_t v;
    v.op         = op_v;
    v.operand_a  = a;
    v.operand_b  = b;
    v.result     = res;
    v.cmp_result = cmp;
    vectors.push_back(v);
  endtask

  // advance to the drive/sample point of the next cycle
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  `include "alu_tb_vectors.svh"

  // run limit scales with the table length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > vectors.size() * 10 + 20) begin
      fail_run("timeout, the DUT stopped answering the handshake");
    end
  end

  //////////////////////
  // stimulus and checks
  //////////////////////
  initial begin
    vector_t     v;
    int unsigned edges;
    alu_word_t   held_result;
    rst_n     = 1'b0;
    req       = 1'b0;
    op        = ALU_ADD;
    operand_a = '0;
    operand_b = '0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    assert (ack === 1'b0 && result === '0 && cmp_result === 1'b0) else
      fail_run("ack_o, result_o or cmp_result_o not clear after reset");
    rst_n = 1'b1;

    foreach (vectors[i]) begin
      v         = vectors[i];
      op        = v.op;
      operand_a = v.operand_a;
      operand_b = v.operand_b;
      req       = 1'b1;
      edges     = 0;
      while (ack !== 1'b1) begin
        next_cycle();
        edges++;
      end
      assert (edges == ACK_LATENCY) else begin
        $display("Error at %0t ns: ack_o rose after %0d edges, expected %0d",
                 $time, edges, ACK_LATENCY);
        fail_run("handshake latency is wrong");
      end
      assert (result === v.result) else
        report_mismatch($sformatf("%s result_o", v.op.name()), result, v.result);
      assert (cmp_result === v.cmp_result) else
        report_mismatch($sformatf("%s cmp_result_o", v.op.name()),
                        alu_word_t'(cmp_result), alu_word_t'(v.cmp_result));

      // a slow requester keeps req high and both results must hold
      held_result = result;
      repeat (i % 4) begin
        next_cycle();
        assert (ack === 1'b1) else fail_run("ack_o dropped while req_i was still high");
        assert (result === held_result) else
          report_mismatch("result_o while held", result, held_result);
        assert (cmp_result === v.cmp_result) else
          report_mismatch("cmp_result_o while held", alu_word_t'(cmp_result),
                          alu_word_t'(v.cmp_result));
      end

      req = 1'b0;
      next_cycle();
      assert (ack === 1'b0) else fail_run("ack_o did not fall on the edge after req_i went low");
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* alu.f */
+incdir+tb
verilog/alu_pkg.sv
verilog/alu_dp_if.sv
verilog/alu_adder.sv
verilog/alu_shifter.sv
verilog/alu_compare.sv
verilog/alu_bitcount.sv
verilog/alu_core.sv
verilog/alu_top.sv
tb/alu_tb.sv

/* Makefile */
# Verilator flow for the alu project
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= alu.f
TB_TOP     ?= alu_tb
RTL_TOP    ?= alu_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary

.PHONY: all lint sim clean

all: sim

# static checks on the RTL top
lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build and run, a $$fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
